/* tb.f */
cpu_pkg.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
writeback_unit.sv
cpu.sv
cpu_props.sv
cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - reg_file.sv
  - fetch_unit.sv
  - decode_unit.sv
  - hazard_unit.sv
  - execute_unit.sv
  - writeback_unit.sv
  - cpu.sv
  - target: test
    files:
      - cpu_props.sv
      - cpu_tb.sv

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 300;
	localparam int MAX_CYCLES      = NUM_TESTS * CYCLES_PER_TEST;
	localparam int RESET_CYCLES    = 8;

	logic                     clk;
	logic                     rst_n_i;
	logic                     imem_we_i;
	logic [cpu_pkg::XLEN-1:0] imem_addr_i;
	logic [cpu_pkg::XLEN-1:0] imem_data_i;
	logic [cpu_pkg::XLEN-1:0] dmem_addr_o;
	logic [cpu_pkg::XLEN-1:0] dmem_wdata_o;
	logic                     dmem_we_o;
	logic [cpu_pkg::XLEN-1:0] dmem_rdata_i;
	logic [cpu_pkg::XLEN-1:0] pc_o;
	logic                     hlt_o;

	logic [15:0] dmem [256];
	logic [15:0] prog [$];
	logic [15:0] st_addr [$];
	logic [15:0] st_data [$];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	integer      seed;
	int          errors;
	int          checks;
	int          cycle_count;

	cpu u_dut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.imem_we_i    (imem_we_i),
		.imem_addr_i  (imem_addr_i),
		.imem_data_i  (imem_data_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_rdata_i (dmem_rdata_i),
		.pc_o         (pc_o),
		.hlt_o        (hlt_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// word-addressed data memory, read in the same cycle
	assign dmem_rdata_i = dmem[dmem_addr_o[8:1]];

	// the strobe is stable by the falling edge, so the store is taken and logged there
	always @(negedge clk) begin
		if (dmem_we_o === 1'b1) begin
			dmem[dmem_addr_o[8:1]] = dmem_wdata_o;
			st_addr.push_back(dmem_addr_o);
			st_data.push_back(dmem_wdata_o);
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [15:0] encode_reg(input logic [3:0] op, input logic [3:0] rd,
			input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] encode_imm(input logic [3:0] op, input logic [3:0] rd,
			input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	function automatic logic [15:0] encode_branch(input logic [2:0] cc, input logic [8:0] off9);
		return {4'hC, cc, off9};
	endfunction

	// arithmetic shift right, one bit at a time with the sign copied in
	function automatic logic [15:0] shift_right_arith(input logic [15:0] v, input logic [3:0] n);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < n; i++)
			r = {r[15], r[15:1]};
		return r;
	endfunction

	task automatic emit(input logic [15:0] word);
		prog.push_back(word);
	endtask

	task automatic expect_store(input logic [15:0] addr, input logic [15:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic clear_bench();
		for (int i = 0; i < 256; i++)
			dmem[i] = {8'(~i), 8'(i)};
		prog.delete();
		st_addr.delete();
		st_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// the program goes in one word per cycle while reset is held
	task automatic load_program();
		int n;
		n = 0;
		rst_n_i = 1'b0;
		foreach (prog[i]) begin
			imem_we_i   = 1'b1;
			imem_addr_i = 16'(2 * i);
			imem_data_i = prog[i];
			@(negedge clk);
			n++;
		end
		imem_we_i = 1'b0;
		while (n < RESET_CYCLES) begin
			@(negedge clk);
			n++;
		end
		rst_n_i = 1'b1;
	endtask

	task automatic run_to_halt(input logic [15:0] hlt_addr);
		int stores_at_halt;
		while (hlt_o !== 1'b1)
			@(negedge clk);
		stores_at_halt = st_addr.size();
		check_word("pc_o", pc_o, hlt_addr);
		repeat (4) @(negedge clk);
		checks++;
		assert (st_addr.size() == stores_at_halt) else begin
			$display("a store reached the data bus after the core halted");
			errors++;
		end
		check_word("pc_o", pc_o, hlt_addr);
	endtask

	task automatic compare_stores();
		int n;
		check_word("number of stores", 16'(st_addr.size()), 16'(exp_addr.size()));
		n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check_word("dmem_addr_o", st_addr[i], exp_addr[i]);
			check_word("dmem_wdata_o", st_data[i], exp_data[i]);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("test %-26s ok", name);
		else
			$display("test %-26s %0d errors", name, errors - errors_before);
	endtask

	task automatic test_arith();
		int          e0;
		logic [31:0] rnd;
		logic [15:0] a;
		logic [15:0] b;
		logic [3:0]  sh_l;
		logic [3:0]  sh_r;
		e0 = errors;
		clear_bench();
		rnd  = $random(seed);
		a    = {rnd[15:8] | 8'h80, rnd[7:0]};
		b    = rnd[31:16];
		rnd  = $random(seed);
		sh_l = rnd[3:0];
		sh_r = rnd[7:4];
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd1, a[7:0]));
		emit(encode_imm(cpu_pkg::OP_LHB, 4'd1, a[15:8]));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd2, b[7:0]));
		emit(encode_imm(cpu_pkg::OP_LHB, 4'd2, b[15:8]));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd10, 8'h40));
		emit(encode_reg(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		emit(encode_reg(cpu_pkg::OP_SUB, 4'd4, 4'd1, 4'd2));
		emit(encode_reg(cpu_pkg::OP_XOR, 4'd5, 4'd1, 4'd2));
		emit(encode_reg(cpu_pkg::OP_SLL, 4'd6, 4'd1, sh_l));
		emit(encode_reg(cpu_pkg::OP_SRA, 4'd7, 4'd1, sh_r));
		for (int k = 0; k < 5; k++)
			emit(encode_reg(cpu_pkg::OP_SW, 4'(3 + k), 4'd10, 4'(k)));
		emit(encode_reg(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0040, a + b);
		expect_store(16'h0042, a - b);
		expect_store(16'h0044, a ^ b);
		expect_store(16'h0046, a << sh_l);
		expect_store(16'h0048, shift_right_arith(a, sh_r));
		load_program();
		run_to_halt(16'(2 * (prog.size() - 1)));
		compare_stores();
		report_test("immediates and arithmetic", e0);
	endtask

	task automatic test_forwarding();
		int          e0;
		logic [31:0] rnd;
		logic [15:0] r1;
		logic [15:0] r2;
		logic [15:0] r3;
		logic [15:0] r4;
		logic [15:0] r5;
		e0 = errors;
		clear_bench();
		rnd = $random(seed);
		r1  = {8'h00, rnd[7:0]};
		r2  = {8'h00, rnd[15:8]};
		r3  = r1 + r2;
		r4  = r3 ^ r1;
		r5  = r4 - r3;
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd1, r1[7:0]));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd2, r2[7:0]));
		emit(encode_reg(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		emit(encode_reg(cpu_pkg::OP_XOR, 4'd4, 4'd3, 4'd1));
		emit(encode_reg(cpu_pkg::OP_SUB, 4'd5, 4'd4, 4'd3));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd11, 8'h60));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd5, 4'd11, 4'd0));
		emit(encode_reg(cpu_pkg::OP_ADD, 4'd6, 4'd5, 4'd5));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd6, 4'd11, 4'd1));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd3, 4'd11, 4'hF));
		emit(encode_reg(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0060, r5);
		expect_store(16'h0062, r5 + r5);
		expect_store(16'h005E, r3);
		load_program();
		run_to_halt(16'(2 * (prog.size() - 1)));
		compare_stores();
		report_test("forwarding", e0);
	endtask

	task automatic test_load_use();
		int          e0;
		logic [31:0] rnd;
		logic [15:0] p;
		logic [15:0] q;
		logic [7:0]  z;
		e0 = errors;
		clear_bench();
		rnd = $random(seed);
		p   = rnd[15:0];
		q   = rnd[31:16];
		rnd = $random(seed);
		z   = rnd[7:0];
		dmem[8'h40] = p;
		dmem[8'h3E] = q;
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd1, 8'h80));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd2, z));
		emit(encode_reg(cpu_pkg::OP_LW, 4'd3, 4'd1, 4'd0));
		emit(encode_reg(cpu_pkg::OP_ADD, 4'd4, 4'd3, 4'd2));
		emit(encode_reg(cpu_pkg::OP_LW, 4'd5, 4'd1, 4'hE));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd5, 4'd1, 4'd1));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd4, 4'd1, 4'd2));
		emit(encode_reg(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0082, q);
		expect_store(16'h0084, p + {8'h00, z});
		load_program();
		run_to_halt(16'(2 * (prog.size() - 1)));
		compare_stores();
		report_test("load-use", e0);
	endtask

	// four flag states, each probed with all eight condition codes
	task automatic test_branches();
		int          e0;
		logic [7:0]  base;
		logic [15:0] addr;
		logic [7:0]  taken_mask [4];
		e0 = errors;
		clear_bench();
		taken_mask = '{8'hB2, 8'h95, 8'hA9, 8'hE9};
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd1, 8'h05));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd2, 8'h03));
		emit(encode_imm(cpu_pkg::OP_LHB, 4'd3, 8'h7F));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd7, 8'hA7));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd8, 8'hB8));
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd9, 8'hC9));
		for (int g = 0; g < 4; g++) begin
			base = 8'(16 + 32 * g);
			emit(encode_imm(cpu_pkg::OP_LLB, 4'd10, base));
			case (g)
				0: emit(encode_reg(cpu_pkg::OP_SUB, 4'd4, 4'd1, 4'd1));
				1: emit(encode_reg(cpu_pkg::OP_SUB, 4'd4, 4'd1, 4'd2));
				2: emit(encode_reg(cpu_pkg::OP_SUB, 4'd4, 4'd2, 4'd1));
				default: emit(encode_reg(cpu_pkg::OP_ADD, 4'd4, 4'd3, 4'd3));
			endcase
			for (int k = 0; k < 8; k++) begin
				addr = 16'(base) + 16'(2 * k);
				emit(encode_branch(3'(k), 9'd2));
				emit(encode_reg(cpu_pkg::OP_SW, 4'd8, 4'd10, 4'(k)));
				emit(encode_reg(cpu_pkg::OP_SW, 4'd9, 4'd10, 4'(k)));
				emit(encode_reg(cpu_pkg::OP_SW, 4'd7, 4'd10, 4'(k)));
				if (!taken_mask[g][k]) begin
					expect_store(addr, 16'h00B8);
					expect_store(addr, 16'h00C9);
				end
				expect_store(addr, 16'h00A7);
			end
		end
		emit(encode_reg(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		load_program();
		run_to_halt(16'(2 * (prog.size() - 1)));
		compare_stores();
		report_test("branches", e0);
	endtask

	task automatic test_pcs_halt();
		int e0;
		e0 = errors;
		clear_bench();
		emit(encode_imm(cpu_pkg::OP_LLB, 4'd10, 8'h30));
		emit(encode_reg(cpu_pkg::OP_PCS, 4'd1, 4'd0, 4'd0));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd1, 4'd10, 4'd0));
		emit(encode_branch(3'd7, 9'd1));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd10, 4'd10, 4'd1));
		emit(encode_reg(cpu_pkg::OP_PCS, 4'd2, 4'd0, 4'd0));
		emit(encode_reg(cpu_pkg::OP_SW, 4'd2, 4'd10, 4'd2));
		emit(encode_reg(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		// sits behind the HLT and must never be fetched
		emit(encode_reg(cpu_pkg::OP_SW, 4'd1, 4'd10, 4'd3));
		expect_store(16'h0030, 16'h0004);
		expect_store(16'h0034, 16'h000C);
		load_program();
		run_to_halt(16'h000E);
		compare_stores();
		report_test("pcs and halt", e0);
	endtask

	initial begin
		rst_n_i     = 1'b0;
		imem_we_i   = 1'b0;
		imem_addr_i = '0;
		imem_data_i = '0;
		seed        = 13042;
		errors      = 0;
		checks      = 0;
		@(negedge clk);
		test_arith();
		test_forwarding();
		test_load_use();
		test_branches();
		test_pcs_halt();
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
	input logic                     clk,
	input logic                     rst_n_i,
	input logic                     hlt_i,
	input logic                     dmem_we_i,
	input logic [cpu_pkg::XLEN-1:0] pc_i
);

	// the first cycle out of reset starts with no halt and no store
	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n_i) |-> !hlt_i && !dmem_we_i)
		else $error("halt or store strobe active in the first cycle after reset");

	// once the core has halted it stays halted until the next reset
	halt_is_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
		hlt_i |=> hlt_i)
		else $error("hlt_o dropped without a reset");

	// instructions are 16-bit words, so the PC never points at an odd byte
	pc_is_even: assert property (@(posedge clk) disable iff (!rst_n_i)
		!pc_i[0])
		else $error("pc_o is odd");

	store_strobe_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(dmem_we_i))
		else $error("dmem_we_o is unknown");

endmodule

bind cpu cpu_props u_props (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.hlt_i     (hlt_o),
	.dmem_we_i (dmem_we_o),
	.pc_i      (pc_o)
);

/* cpu.sv */
`timescale 1ns/1ps

module cpu (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     imem_we_i,
	input  logic [cpu_pkg::XLEN-1:0] imem_addr_i,
	input  logic [cpu_pkg::XLEN-1:0] imem_data_i,
	output logic [cpu_pkg::XLEN-1:0] dmem_addr_o,
	output logic [cpu_pkg::XLEN-1:0] dmem_wdata_o,
	output logic                     dmem_we_o,
	input  logic [cpu_pkg::XLEN-1:0] dmem_rdata_i,
	output logic [cpu_pkg::XLEN-1:0] pc_o,
	output logic                     hlt_o
);

	cpu_pkg::ifid_t    ifid;
	cpu_pkg::idex_t    idex;
	cpu_pkg::exmem_t   exmem;
	cpu_pkg::memwb_t   memwb;
	cpu_pkg::fwd_sel_e fwd_a;
	cpu_pkg::fwd_sel_e fwd_b;

	logic                       stall;
	logic                       br_taken;
	logic [cpu_pkg::XLEN-1:0]   br_target;
	logic [cpu_pkg::REG_AW-1:0] rf_raddr_a;
	logic [cpu_pkg::REG_AW-1:0] rf_raddr_b;
	logic [cpu_pkg::XLEN-1:0]   rf_rdata_a;
	logic [cpu_pkg::XLEN-1:0]   rf_rdata_b;
	logic                       rf_we;
	logic [cpu_pkg::REG_AW-1:0] rf_waddr;
	logic [cpu_pkg::XLEN-1:0]   rf_wdata;

	fetch_unit u_fetch (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.imem_we_i   (imem_we_i),
		.imem_addr_i (imem_addr_i),
		.imem_data_i (imem_data_i),
		.stall_i     (stall),
		.br_taken_i  (br_taken),
		.br_target_i (br_target),
		.ifid_o      (ifid),
		.pc_o        (pc_o)
	);

	decode_unit u_decode (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.ifid_i       (ifid),
		.stall_i      (stall),
		.flush_i      (br_taken),
		.rf_raddr_a_o (rf_raddr_a),
		.rf_raddr_b_o (rf_raddr_b),
		.rf_rdata_a_i (rf_rdata_a),
		.rf_rdata_b_i (rf_rdata_b),
		.idex_o       (idex)
	);

	reg_file u_rf (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.raddr_a_i (rf_raddr_a),
		.raddr_b_i (rf_raddr_b),
		.rdata_a_o (rf_rdata_a),
		.rdata_b_o (rf_rdata_b),
		.we_i      (rf_we),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata)
	);

	hazard_unit u_hazard (
		.ifid_i  (ifid),
		.idex_i  (idex),
		.exmem_i (exmem),
		.memwb_i (memwb),
		.stall_o (stall),
		.fwd_a_o (fwd_a),
		.fwd_b_o (fwd_b)
	);

	execute_unit u_execute (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.idex_i       (idex),
		.fwd_a_i      (fwd_a),
		.fwd_b_i      (fwd_b),
		.exmem_fwd_i  (exmem),
		.memwb_fwd_i  (memwb),
		.br_taken_o   (br_taken),
		.br_target_o  (br_target),
		.exmem_o      (exmem),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o)
	);

	writeback_unit u_writeback (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.exmem_i      (exmem),
		.dmem_rdata_i (dmem_rdata_i),
		.memwb_o      (memwb),
		.rf_we_o      (rf_we),
		.rf_waddr_o   (rf_waddr),
		.rf_wdata_o   (rf_wdata),
		.hlt_o        (hlt_o)
	);

endmodule

/* writeback_unit.sv */
`timescale 1ns/1ps

module writeback_unit (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  cpu_pkg::exmem_t            exmem_i,
	input  logic [cpu_pkg::XLEN-1:0]   dmem_rdata_i,
	output cpu_pkg::memwb_t            memwb_o,
	output logic                       rf_we_o,
	output logic [cpu_pkg::REG_AW-1:0] rf_waddr_o,
	output logic [cpu_pkg::XLEN-1:0]   rf_wdata_o,
	output logic                       hlt_o
);

	cpu_pkg::memwb_t memwb_q;
	logic            hlt_now;
	logic            hlt_q;

	// the data bus answers in the same cycle, so the load word is captured here
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			memwb_q.valid <= 1'b0;
		else
			memwb_q.valid <= exmem_i.valid;
		memwb_q.opcode <= exmem_i.opcode;
		memwb_q.rd     <= exmem_i.rd;
		memwb_q.wb_val <= (exmem_i.opcode == cpu_pkg::OP_LW) ? dmem_rdata_i : exmem_i.result;
	end

	assign rf_we_o    = memwb_q.valid && cpu_pkg::writes_rd(memwb_q.opcode);
	assign rf_waddr_o = memwb_q.rd;
	assign rf_wdata_o = memwb_q.wb_val;

	assign hlt_now = memwb_q.valid && memwb_q.opcode == cpu_pkg::OP_HLT;

	// sticky until reset, even though more HLT copies follow the first one
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			hlt_q <= 1'b0;
		else if (hlt_now)
			hlt_q <= 1'b1;
	end

	assign hlt_o   = hlt_q || hlt_now;
	assign memwb_o = memwb_q;

endmodule

/* execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  cpu_pkg::idex_t           idex_i,
	input  cpu_pkg::fwd_sel_e        fwd_a_i,
	input  cpu_pkg::fwd_sel_e        fwd_b_i,
	input  cpu_pkg::exmem_t          exmem_fwd_i,
	input  cpu_pkg::memwb_t          memwb_fwd_i,
	output logic                     br_taken_o,
	output logic [cpu_pkg::XLEN-1:0] br_target_o,
	output cpu_pkg::exmem_t          exmem_o,
	output logic [cpu_pkg::XLEN-1:0] dmem_addr_o,
	output logic [cpu_pkg::XLEN-1:0] dmem_wdata_o,
	output logic                     dmem_we_o
);

	logic [cpu_pkg::XLEN-1:0] op_a;
	logic [cpu_pkg::XLEN-1:0] op_b;
	logic [cpu_pkg::XLEN-1:0] imm_x2;
	logic [cpu_pkg::XLEN-1:0] sum;
	logic [cpu_pkg::XLEN-1:0] diff;
	logic [cpu_pkg::XLEN-1:0] result;
	logic [3:0]               shamt;
	logic                     add_ovf;
	logic                     sub_ovf;
	logic                     cond;
	cpu_pkg::flags_t          flags_q;
	cpu_pkg::exmem_t          exmem_q;

	always_comb begin
		case (fwd_a_i)
			cpu_pkg::FWD_EXMEM: op_a = exmem_fwd_i.result;
			cpu_pkg::FWD_MEMWB: op_a = memwb_fwd_i.wb_val;
			default:            op_a = idex_i.rs_val;
		endcase
		case (fwd_b_i)
			cpu_pkg::FWD_EXMEM: op_b = exmem_fwd_i.result;
			cpu_pkg::FWD_MEMWB: op_b = memwb_fwd_i.wb_val;
			default:            op_b = idex_i.rt_val;
		endcase
	end

	assign imm_x2 = {idex_i.imm[cpu_pkg::XLEN-2:0], 1'b0};
	assign shamt  = idex_i.imm[3:0];
	assign sum    = op_a + op_b;
	assign diff   = op_a - op_b;

	// signed overflow, with both sums wrapping in 16 bits
	assign add_ovf = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
	assign sub_ovf = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);

	always_comb begin
		case (idex_i.opcode)
			cpu_pkg::OP_ADD: result = sum;
			cpu_pkg::OP_SUB: result = diff;
			cpu_pkg::OP_XOR: result = op_a ^ op_b;
			cpu_pkg::OP_SLL: result = op_a << shamt;
			cpu_pkg::OP_SRA: result = $signed(op_a) >>> shamt;
			cpu_pkg::OP_LLB: result = {op_a[15:8], idex_i.imm[7:0]};
			cpu_pkg::OP_LHB: result = {idex_i.imm[7:0], op_a[7:0]};
			cpu_pkg::OP_PCS: result = idex_i.pc2;
			default:         result = '0;
		endcase
	end

	// flags of the instruction just ahead land here at the end of its ALU cycle,
	// in time for a branch right behind it
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else if (idex_i.valid) begin
			if (idex_i.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_XOR,
					cpu_pkg::OP_SLL, cpu_pkg::OP_SRA})
				flags_q.z <= result == '0;
			if (idex_i.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB}) begin
				flags_q.v <= (idex_i.opcode == cpu_pkg::OP_SUB) ? sub_ovf : add_ovf;
				flags_q.n <= result[15];
			end
		end
	end

	always_comb begin
		case (idex_i.ccode)
			cpu_pkg::CC_NE: cond = !flags_q.z;
			cpu_pkg::CC_EQ: cond = flags_q.z;
			cpu_pkg::CC_GT: cond = !flags_q.z && !flags_q.n;
			cpu_pkg::CC_LT: cond = flags_q.n;
			cpu_pkg::CC_GE: cond = flags_q.z || !flags_q.n;
			cpu_pkg::CC_LE: cond = flags_q.n || flags_q.z;
			cpu_pkg::CC_OV: cond = flags_q.v;
			default:        cond = 1'b1;
		endcase
	end

	assign br_taken_o  = idex_i.valid && idex_i.opcode == cpu_pkg::OP_B && cond;
	assign br_target_o = idex_i.pc2 + imm_x2;

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			exmem_q.valid <= 1'b0;
		else
			exmem_q.valid <= idex_i.valid;
		exmem_q.opcode <= idex_i.opcode;
		exmem_q.rd     <= idex_i.rd;
		exmem_q.result <= result;
		exmem_q.addr   <= op_a + imm_x2;
		exmem_q.wdata  <= op_b;
	end

	assign exmem_o      = exmem_q;
	assign dmem_addr_o  = exmem_q.addr;
	assign dmem_wdata_o = exmem_q.wdata;
	assign dmem_we_o    = exmem_q.valid && exmem_q.opcode == cpu_pkg::OP_SW;

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input  cpu_pkg::ifid_t     ifid_i,
	input  cpu_pkg::idex_t     idex_i,
	input  cpu_pkg::exmem_t    exmem_i,
	input  cpu_pkg::memwb_t    memwb_i,
	output logic               stall_o,
	output cpu_pkg::fwd_sel_e  fwd_a_o,
	output cpu_pkg::fwd_sel_e  fwd_b_o
);

	cpu_pkg::opcode_e id_op;
	logic             id_needs_a;
	logic             id_needs_b;
	logic             load_in_ex;

	assign id_op = ifid_i.instr.r_fmt.opcode;

	assign id_needs_a = cpu_pkg::uses_a(id_op) && cpu_pkg::src_a(ifid_i.instr) == idex_i.rd;
	assign id_needs_b = cpu_pkg::uses_b(id_op) && cpu_pkg::src_b(ifid_i.instr) == idex_i.rd;

	// the load data only exists in MEM, so the consumer waits one cycle
	assign load_in_ex = idex_i.valid && idex_i.opcode == cpu_pkg::OP_LW && idex_i.rd != '0;
	assign stall_o    = load_in_ex && ifid_i.valid && (id_needs_a || id_needs_b);

	// the younger producer in EX/MEM has the newer value
	function automatic cpu_pkg::fwd_sel_e pick(input logic [cpu_pkg::REG_AW-1:0] src,
			input cpu_pkg::exmem_t em, input cpu_pkg::memwb_t mw);
		if (em.valid && cpu_pkg::writes_rd(em.opcode) && em.rd != '0 && em.rd == src)
			return cpu_pkg::FWD_EXMEM;
		if (mw.valid && cpu_pkg::writes_rd(mw.opcode) && mw.rd != '0 && mw.rd == src)
			return cpu_pkg::FWD_MEMWB;
		return cpu_pkg::FWD_RF;
	endfunction

	assign fwd_a_o = pick(idex_i.rs, exmem_i, memwb_i);
	assign fwd_b_o = pick(idex_i.rt, exmem_i, memwb_i);

endmodule

/* decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  cpu_pkg::ifid_t             ifid_i,
	input  logic                       stall_i,
	input  logic                       flush_i,
	output logic [cpu_pkg::REG_AW-1:0] rf_raddr_a_o,
	output logic [cpu_pkg::REG_AW-1:0] rf_raddr_b_o,
	input  logic [cpu_pkg::XLEN-1:0]   rf_rdata_a_i,
	input  logic [cpu_pkg::XLEN-1:0]   rf_rdata_b_i,
	output cpu_pkg::idex_t             idex_o
);

	cpu_pkg::instr_u          ins;
	cpu_pkg::opcode_e         op;
	logic [cpu_pkg::XLEN-1:0] imm;
	logic                     issue;
	cpu_pkg::idex_t           idex_q;

	assign ins = ifid_i.instr;
	assign op  = ins.r_fmt.opcode;

	assign rf_raddr_a_o = cpu_pkg::src_a(ins);
	assign rf_raddr_b_o = cpu_pkg::src_b(ins);

	// shifts, loads and stores carry a 4-bit immediate in the rt field
	always_comb begin
		case (op)
			cpu_pkg::OP_LLB, cpu_pkg::OP_LHB:
				imm = {{8{ins.i_fmt.imm8[7]}}, ins.i_fmt.imm8};
			cpu_pkg::OP_B:
				imm = {{7{ins.b_fmt.off9[8]}}, ins.b_fmt.off9};
			default:
				imm = {{12{ins.r_fmt.rt[3]}}, ins.r_fmt.rt};
		endcase
	end

	// unused opcodes and held or squashed slots go down the pipe as bubbles
	assign issue = ifid_i.valid && cpu_pkg::is_legal(op) && !stall_i && !flush_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			idex_q.valid <= 1'b0;
		else
			idex_q.valid <= issue;
		idex_q.opcode <= op;
		idex_q.rd     <= ins.r_fmt.rd;
		idex_q.rs     <= rf_raddr_a_o;
		idex_q.rt     <= rf_raddr_b_o;
		idex_q.rs_val <= rf_rdata_a_i;
		idex_q.rt_val <= rf_rdata_b_i;
		idex_q.imm    <= imm;
		idex_q.ccode  <= ins.b_fmt.ccode;
		idex_q.pc2    <= ifid_i.pc2;
	end

	assign idex_o = idex_q;

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     imem_we_i,
	input  logic [cpu_pkg::XLEN-1:0] imem_addr_i,
	input  logic [cpu_pkg::XLEN-1:0] imem_data_i,
	input  logic                     stall_i,
	input  logic                     br_taken_i,
	input  logic [cpu_pkg::XLEN-1:0] br_target_i,
	output cpu_pkg::ifid_t           ifid_o,
	output logic [cpu_pkg::XLEN-1:0] pc_o
);

	logic [cpu_pkg::XLEN-1:0] imem [cpu_pkg::IMEM_DEPTH];
	logic [cpu_pkg::XLEN-1:0] pc_q;
	logic [cpu_pkg::XLEN-1:0] pc_plus2;
	logic [cpu_pkg::XLEN-1:0] pc_next;
	cpu_pkg::instr_u          fetch_word;
	cpu_pkg::ifid_t           ifid_q;
	logic                     fetch_hlt;

	// the program is written only while the core sits in reset
	always_ff @(posedge clk) begin
		if (!rst_n_i && imem_we_i)
			imem[imem_addr_i[cpu_pkg::IMEM_AW:1]] <= imem_data_i;
	end

	assign fetch_word = imem[pc_q[cpu_pkg::IMEM_AW:1]];
	assign pc_plus2   = pc_q + cpu_pkg::XLEN'(2);
	assign fetch_hlt  = fetch_word.r_fmt.opcode == cpu_pkg::OP_HLT;

	// a redirect wins over everything, a halt parks the PC on its own address
	always_comb begin
		if (br_taken_i)
			pc_next = br_target_i;
		else if (fetch_hlt || stall_i)
			pc_next = pc_q;
		else
			pc_next = pc_plus2;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			pc_q <= '0;
		else
			pc_q <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ifid_q.valid <= 1'b0;
		else if (br_taken_i)
			ifid_q.valid <= 1'b0;
		else if (!stall_i)
			ifid_q.valid <= 1'b1;
		if (!stall_i) begin
			ifid_q.pc2   <= pc_plus2;
			ifid_q.instr <= fetch_word;
		end
	end

	assign ifid_o = ifid_q;
	assign pc_o   = pc_q;

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic [cpu_pkg::REG_AW-1:0] raddr_a_i,
	input  logic [cpu_pkg::REG_AW-1:0] raddr_b_i,
	output logic [cpu_pkg::XLEN-1:0]   rdata_a_o,
	output logic [cpu_pkg::XLEN-1:0]   rdata_b_o,
	input  logic                       we_i,
	input  logic [cpu_pkg::REG_AW-1:0] waddr_i,
	input  logic [cpu_pkg::XLEN-1:0]   wdata_i
);

	logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::REG_AW];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2**cpu_pkg::REG_AW; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// a value written this cycle is already visible to decode
	function automatic logic [cpu_pkg::XLEN-1:0] rd_port(input logic [cpu_pkg::REG_AW-1:0] a);
		if (a == '0)
			return '0;
		if (we_i && waddr_i == a)
			return wdata_i;
		return regs[a];
	endfunction

	always_comb begin
		rdata_a_o = rd_port(raddr_a_i);
		rdata_b_o = rd_port(raddr_b_i);
	end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

	localparam int XLEN       = 16;
	localparam int REG_AW     = 4;
	localparam int IMEM_DEPTH = 256;
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LLB = 4'hA,
		OP_LHB = 4'hB,
		OP_B   = 4'hC,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} opcode_e;

	typedef enum logic [2:0] {
		CC_NE = 3'd0,
		CC_EQ = 3'd1,
		CC_GT = 3'd2,
		CC_LT = 3'd3,
		CC_GE = 3'd4,
		CC_LE = 3'd5,
		CC_OV = 3'd6,
		CC_UN = 3'd7
	} ccode_e;

	typedef struct packed {
		opcode_e           opcode;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
	} r_fmt_t;

	typedef struct packed {
		opcode_e           opcode;
		logic [REG_AW-1:0] rd;
		logic [7:0]        imm8;
	} i_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		ccode_e     ccode;
		logic [8:0] off9;
	} b_fmt_t;

	// one instruction word, seen through whichever layout its opcode uses
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
	} instr_u;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef enum logic [1:0] {
		FWD_RF    = 2'b00,
		FWD_MEMWB = 2'b01,
		FWD_EXMEM = 2'b10
	} fwd_sel_e;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc2;
		instr_u          instr;
	} ifid_t;

	typedef struct packed {
		logic              valid;
		opcode_e           opcode;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [XLEN-1:0]   rs_val;
		logic [XLEN-1:0]   rt_val;
		logic [XLEN-1:0]   imm;
		ccode_e            ccode;
		logic [XLEN-1:0]   pc2;
	} idex_t;

	typedef struct packed {
		logic              valid;
		opcode_e           opcode;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   result;
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;
	} exmem_t;

	typedef struct packed {
		logic              valid;
		opcode_e           opcode;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   wb_val;
	} memwb_t;

	// byte loads modify rd, so rd is their first source
	function automatic logic [REG_AW-1:0] src_a(input instr_u ins);
		if (ins.r_fmt.opcode == OP_LLB || ins.r_fmt.opcode == OP_LHB)
			return ins.r_fmt.rd;
		return ins.r_fmt.rs;
	endfunction

	// a store takes its data from rd
	function automatic logic [REG_AW-1:0] src_b(input instr_u ins);
		if (ins.r_fmt.opcode == OP_SW)
			return ins.r_fmt.rd;
		return ins.r_fmt.rt;
	endfunction

	function automatic logic uses_a(input opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA,
			OP_LW, OP_SW, OP_LLB, OP_LHB};
	endfunction

	function automatic logic uses_b(input opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_XOR, OP_SW};
	endfunction

	function automatic logic writes_rd(input opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA,
			OP_LW, OP_LLB, OP_LHB, OP_PCS};
	endfunction

	function automatic logic is_legal(input opcode_e op);
		return !(op inside {4'h3, 4'h6, 4'h7, 4'hD});
	endfunction

endpackage
